//--- verilog/seq_isa_pkg.sv
package seq_isa_pkg;

   localparam int XLEN      = 32;
   localparam int CNT_W     = $clog2(XLEN);
   localparam int CNT_BIT2  = 2;   // bit index that carries the +4
   localparam int OPC_LSB   = 0;
   localparam int OPC_W     = 7;
   localparam int RD_LSB    = 7;
   localparam int RD_WIDTH  = 5;
   localparam int U_IMM_LSB = 12;  // first bit of the upper immediate

   typedef enum logic [OPC_W-1:0] {
      OP_LUI   = 7'b0110111,
      OP_AUIPC = 7'b0010111,
      OP_JAL   = 7'b1101111,
      OP_OTHER = 7'b0010011
   } opcode_e;

   // anything unknown executes as a plain pc+4
   function automatic opcode_e decode_op(logic [OPC_W-1:0] bits);
      case (bits)
         OP_JAL, OP_AUIPC, OP_LUI: return opcode_e'(bits);
         default:                  return OP_OTHER;
      endcase
   endfunction

   // j-format with bits 1:0 zero since targets are word aligned
   function automatic logic [XLEN-1:0] imm_j(logic [XLEN-1:0] ir);
      return {{12{ir[31]}}, ir[19:12], ir[20], ir[30:22], 2'b00};
   endfunction

   function automatic logic [XLEN-1:0] imm_u(logic [XLEN-1:0] ir);
      return {ir[31:U_IMM_LSB], {U_IMM_LSB{1'b0}}};
   endfunction

endpackage

//--- verilog/seq_bus_pkg.sv
package seq_bus_pkg;

   localparam int ADR_W = 32;
   localparam int DAT_W = 32;

   localparam logic [ADR_W-1:0] RESET_PC    = 32'h100;
   localparam logic [ADR_W-1:0] RESULT_BASE = 32'h8000;  // rd n lands at base + 4*n

   typedef enum logic [1:0] {
      GNT_NONE,
      GNT_WB,
      GNT_FETCH
   } grant_e;

endpackage

//--- verilog/mem_req_if.sv
`timescale 1ns/1ns

interface mem_req_if;
   import seq_bus_pkg::*;

   logic             req;
   logic             ack;
   logic             we;
   logic [ADR_W-1:0] adr;
   logic [DAT_W-1:0] wdata;
   logic [DAT_W-1:0] rdata;  // valid while ack is high

   modport requester (
      output req, we, adr, wdata,
      input  ack, rdata
   );

   modport arbiter (
      input  req, we, adr, wdata,
      output ack, rdata
   );

endinterface

//--- verilog/serial_shift_reg.sv
`timescale 1ns/1ns

module serial_shift_reg #(
   parameter logic [seq_isa_pkg::XLEN-1:0] INIT = '0
) (
   input  logic                           clk,
   input  logic                           i_rst,
   input  logic                           i_en,
   input  logic                           i_d,
   output logic                           o_q,
   output logic [seq_isa_pkg::XLEN-1:1]   o_par
);
   import seq_isa_pkg::*;

   logic [XLEN-1:0] data;

   always_ff @(posedge clk) begin
      if (i_rst) begin
         data <= INIT;
      end else if (i_en) begin
         data <= {i_d, data[XLEN-1:1]};  // new bit enters at the top
      end
   end

   assign o_q   = data[0];
   assign o_par = data[XLEN-1:1];

endmodule

//--- verilog/serial_counter.sv
`timescale 1ns/1ns

module serial_counter (
   input  logic clk,
   input  logic i_rst,
   input  logic i_start,
   output logic o_pc_en,
   output logic o_cnt2,
   output logic o_cnt12to31,
   output logic o_cnt_done
);
   import seq_isa_pkg::*;

   logic             active;
   logic [CNT_W-1:0] idx;

   always_ff @(posedge clk) begin
      if (i_rst) begin
         active <= 1'b0;
         idx    <= '0;
      end else if (i_start) begin
         active <= 1'b1;
         idx    <= '0;
      end else if (active) begin
         idx <= idx + 1'b1;  // wraps back to 0 after the last bit
         if (idx == CNT_W'(XLEN - 1)) begin
            active <= 1'b0;
         end
      end
   end

   assign o_pc_en     = active;
   assign o_cnt2      = active & (idx == CNT_W'(CNT_BIT2));
   assign o_cnt12to31 = active & (idx >= CNT_W'(U_IMM_LSB));
   assign o_cnt_done  = active & (idx == CNT_W'(XLEN - 1));

   // a new fetch can only finish once the previous word is fully shifted
   a_no_restart: assert property (@(posedge clk) disable iff (i_rst)
      i_start |-> !active);

endmodule

//--- verilog/serial_pc_ctrl.sv
`timescale 1ns/1ns

module serial_pc_ctrl (
   input  logic         clk,
   input  logic         i_rst,
   input  logic         i_pc_en,
   input  logic         i_cnt2,
   input  logic         i_cnt12to31,
   input  logic         i_jump,
   input  logic         i_utype,
   input  logic         i_pc_rel,
   input  logic         i_jal,
   input  logic         i_imm,
   output logic         o_rd,
   output logic         o_fetch_done,
   mem_req_if.requester fetch
);
   import seq_isa_pkg::*;
   import seq_bus_pkg::*;

   typedef enum logic [1:0] {
      F_REQ,    // req high and waiting for ack
      F_DRAIN,  // req dropped and waiting for ack to fall
      F_RUN     // word is being executed
   } fetch_state_e;

   fetch_state_e    state;
   logic            pc;
   logic [XLEN-1:1] pc_par;
   logic            new_pc;
   logic            pc_plus_4;
   logic            pc_plus_4_cy;
   logic            pc_plus_4_cy_r;
   logic            pc_plus_offset;
   logic            pc_plus_offset_cy;
   logic            pc_plus_offset_cy_r;
   logic            offset_a;
   logic            offset_b;

   serial_shift_reg #(
      .INIT (RESET_PC)
   ) pc_reg (
      .clk   (clk),
      .i_rst (i_rst),
      .i_en  (i_pc_en),
      .i_d   (new_pc),
      .o_q   (pc),
      .o_par (pc_par)
   );

   assign {pc_plus_4_cy, pc_plus_4} = {1'b0, pc} + {1'b0, i_cnt2} + {1'b0, pc_plus_4_cy_r};

   // lui has pc_rel low so the sum is just the immediate
   assign offset_a = i_pc_rel & pc;
   assign offset_b = i_imm & (i_cnt12to31 | ~i_utype);  // u-imm only feeds bits 12..31
   assign {pc_plus_offset_cy, pc_plus_offset} =
      {1'b0, offset_a} + {1'b0, offset_b} + {1'b0, pc_plus_offset_cy_r};

   assign new_pc = i_jump ? pc_plus_offset : pc_plus_4;
   assign o_rd   = (i_utype & pc_plus_offset) | (i_jal & pc_plus_4);

   always_ff @(posedge clk) begin
      pc_plus_4_cy_r      <= i_pc_en & pc_plus_4_cy;
      pc_plus_offset_cy_r <= i_pc_en & pc_plus_offset_cy;
   end

   always_ff @(posedge clk) begin
      if (i_rst) begin
         state <= F_REQ;
      end else begin
         case (state)
            F_REQ:   if (fetch.ack) state <= F_DRAIN;
            F_DRAIN: if (!fetch.ack) state <= F_RUN;
            F_RUN:   if (!i_pc_en) state <= F_REQ;
            default: state <= F_REQ;
         endcase
      end
   end

   // next req goes up on the cycle after cnt_done when the new pc is complete
   assign fetch.req    = (state == F_REQ) | ((state == F_RUN) & ~i_pc_en);
   assign fetch.we     = 1'b0;
   assign fetch.adr    = {pc_par, pc};
   assign fetch.wdata  = '0;
   assign o_fetch_done = (state == F_DRAIN) & ~fetch.ack;

   // address holds while the fetch waits for ack
   a_req_held: assert property (@(posedge clk) disable iff (i_rst)
      fetch.req && !fetch.ack |=> fetch.req && $stable(fetch.adr));

endmodule

//--- verilog/instr_decoder.sv
`timescale 1ns/1ns

module instr_decoder (
   input  logic                               clk,
   input  logic                               i_rst,
   input  logic                               i_fetch_ack,
   input  logic [seq_bus_pkg::DAT_W-1:0]      i_rdata,
   input  logic                               i_pc_en,
   input  logic                               i_cnt12to31,
   output logic                               o_jump,
   output logic                               o_utype,
   output logic                               o_pc_rel,
   output logic                               o_jal,
   output logic                               o_imm,
   output logic                               o_rd_valid,
   output logic [seq_isa_pkg::RD_WIDTH-1:0]   o_rd_index
);
   import seq_isa_pkg::*;

   opcode_e         op;
   opcode_e         op_in;
   logic [XLEN-1:0] imm_load;
   logic [XLEN-1:0] imm_sr;
   logic            imm_shift;

   assign op_in = decode_op(i_rdata[OPC_LSB +: OPC_W]);

   // u-type keeps only the upper 20 bits, they shift out during bits 12..31
   assign imm_load = (op_in == OP_JAL) ? imm_j(i_rdata) : (imm_u(i_rdata) >> U_IMM_LSB);
   assign imm_shift = i_pc_en & (~o_utype | i_cnt12to31);

   always_ff @(posedge clk) begin
      if (i_rst) begin
         op <= OP_OTHER;
      end else if (i_fetch_ack) begin
         op <= op_in;
      end
   end

   always_ff @(posedge clk) begin
      if (i_fetch_ack) begin
         o_rd_index <= i_rdata[RD_LSB +: RD_WIDTH];
         imm_sr     <= imm_load;
      end else if (imm_shift) begin
         imm_sr <= {1'b0, imm_sr[XLEN-1:1]};
      end
   end

   assign o_jump     = (op == OP_JAL);
   assign o_jal      = (op == OP_JAL);
   assign o_utype    = (op == OP_AUIPC) | (op == OP_LUI);
   assign o_pc_rel   = (op == OP_JAL) | (op == OP_AUIPC);
   assign o_rd_valid = (op != OP_OTHER);
   assign o_imm      = imm_sr[0];

endmodule

//--- verilog/rd_writeback.sv
`timescale 1ns/1ns

module rd_writeback (
   input  logic                             clk,
   input  logic                             i_rst,
   input  logic                             i_pc_en,
   input  logic                             i_cnt_done,
   input  logic                             i_rd_bit,
   input  logic                             i_rd_valid,
   input  logic [seq_isa_pkg::RD_WIDTH-1:0] i_rd_index,
   mem_req_if.requester                     wb
);
   import seq_isa_pkg::*;
   import seq_bus_pkg::*;

   logic [XLEN-1:0]  rd_sr;
   logic [ADR_W-1:0] adr_r;
   logic             req_r;

   always_ff @(posedge clk) begin
      if (i_pc_en) begin
         rd_sr <= {i_rd_bit, rd_sr[XLEN-1:1]};  // bit 0 arrives first
      end
      if (i_cnt_done) begin
         adr_r <= RESULT_BASE + ADR_W'({i_rd_index, 2'b00});
      end
   end

   // x0 is never written
   always_ff @(posedge clk) begin
      if (i_rst) begin
         req_r <= 1'b0;
      end else if (i_cnt_done && i_rd_valid && (i_rd_index != '0)) begin
         req_r <= 1'b1;
      end else if (wb.ack) begin
         req_r <= 1'b0;
      end
   end

   assign wb.req   = req_r;
   assign wb.we    = 1'b1;
   assign wb.adr   = adr_r;
   assign wb.wdata = rd_sr;

endmodule

//--- verilog/mem_arbiter.sv
`timescale 1ns/1ns

module mem_arbiter (
   input  logic                          clk,
   input  logic                          i_rst,
   mem_req_if.arbiter                    wb,
   mem_req_if.arbiter                    fetch,
   output logic                          o_mem_req,
   output logic                          o_mem_we,
   output logic [seq_bus_pkg::ADR_W-1:0] o_mem_adr,
   output logic [seq_bus_pkg::DAT_W-1:0] o_mem_wdata,
   input  logic                          i_mem_ack,
   input  logic [seq_bus_pkg::DAT_W-1:0] i_mem_rdata
);
   import seq_bus_pkg::*;

   grant_e gnt;

   always_ff @(posedge clk) begin
      if (i_rst) begin
         gnt <= GNT_NONE;
      end else begin
         case (gnt)
            GNT_NONE: begin
               if (!i_mem_ack) begin
                  if (wb.req) gnt <= GNT_WB;  // write-back wins a tie
                  else if (fetch.req) gnt <= GNT_FETCH;
               end
            end
            GNT_WB:    if (!wb.req && !i_mem_ack) gnt <= GNT_NONE;
            GNT_FETCH: if (!fetch.req && !i_mem_ack) gnt <= GNT_NONE;
            default:   gnt <= GNT_NONE;
         endcase
      end
   end

   always_comb begin
      o_mem_req   = 1'b0;
      o_mem_we    = fetch.we;
      o_mem_adr   = fetch.adr;
      o_mem_wdata = fetch.wdata;
      if (gnt == GNT_WB) begin
         o_mem_req   = wb.req;
         o_mem_we    = wb.we;
         o_mem_adr   = wb.adr;
         o_mem_wdata = wb.wdata;
      end else if (gnt == GNT_FETCH) begin
         o_mem_req = fetch.req;
      end
   end

   assign wb.ack      = (gnt == GNT_WB) & i_mem_ack;
   assign fetch.ack   = (gnt == GNT_FETCH) & i_mem_ack;
   assign wb.rdata    = i_mem_rdata;
   assign fetch.rdata = i_mem_rdata;

   // a rising ack goes only to the one side that still requests
   a_one_ack: assert property (@(posedge clk) disable iff (i_rst)
      $rose(i_mem_ack) |-> (wb.ack && wb.req) || (fetch.ack && fetch.req));

   // memory may only answer a request this arbiter has granted
   a_ack_granted: assert property (@(posedge clk) disable iff (i_rst)
      i_mem_ack |-> gnt != GNT_NONE);

endmodule

//--- verilog/serial_seq_top.sv
`timescale 1ns/1ns

module serial_seq_top (
   input  logic                          clk,
   input  logic                          i_rst,
   output logic                          o_mem_req,
   output logic                          o_mem_we,
   output logic [seq_bus_pkg::ADR_W-1:0] o_mem_adr,
   output logic [seq_bus_pkg::DAT_W-1:0] o_mem_wdata,
   input  logic                          i_mem_ack,
   input  logic [seq_bus_pkg::DAT_W-1:0] i_mem_rdata
);
   import seq_isa_pkg::*;

   logic                pc_en;
   logic                cnt2;
   logic                cnt12to31;
   logic                cnt_done;
   logic                fetch_done;
   logic                imm_bit;
   logic                jump;
   logic                utype;
   logic                pc_rel;
   logic                jal;
   logic                rd_bit;
   logic                rd_valid_op;
   logic [RD_WIDTH-1:0] rd_index;

   mem_req_if fetch_bus ();
   mem_req_if wb_bus ();

   serial_counter counter_i (
      .clk         (clk),
      .i_rst       (i_rst),
      .i_start     (fetch_done),  // count starts once ack has fallen
      .o_pc_en     (pc_en),
      .o_cnt2      (cnt2),
      .o_cnt12to31 (cnt12to31),
      .o_cnt_done  (cnt_done)
   );

   serial_pc_ctrl pc_ctrl_i (
      .clk          (clk),
      .i_rst        (i_rst),
      .i_pc_en      (pc_en),
      .i_cnt2       (cnt2),
      .i_cnt12to31  (cnt12to31),
      .i_jump       (jump),
      .i_utype      (utype),
      .i_pc_rel     (pc_rel),
      .i_jal        (jal),
      .i_imm        (imm_bit),
      .o_rd         (rd_bit),
      .o_fetch_done (fetch_done),
      .fetch        (fetch_bus.requester)
   );

   instr_decoder decoder_i (
      .clk         (clk),
      .i_rst       (i_rst),
      .i_fetch_ack (fetch_bus.ack),
      .i_rdata     (fetch_bus.rdata),
      .i_pc_en     (pc_en),
      .i_cnt12to31 (cnt12to31),
      .o_jump      (jump),
      .o_utype     (utype),
      .o_pc_rel    (pc_rel),
      .o_jal       (jal),
      .o_imm       (imm_bit),
      .o_rd_valid  (rd_valid_op),
      .o_rd_index  (rd_index)
   );

   rd_writeback writeback_i (
      .clk        (clk),
      .i_rst      (i_rst),
      .i_pc_en    (pc_en),
      .i_cnt_done (cnt_done),
      .i_rd_bit   (rd_bit),
      .i_rd_valid (rd_valid_op),
      .i_rd_index (rd_index),
      .wb         (wb_bus.requester)
   );

   mem_arbiter arbiter_i (
      .clk         (clk),
      .i_rst       (i_rst),
      .wb          (wb_bus.arbiter),
      .fetch       (fetch_bus.arbiter),
      .o_mem_req   (o_mem_req),
      .o_mem_we    (o_mem_we),
      .o_mem_adr   (o_mem_adr),
      .o_mem_wdata (o_mem_wdata),
      .i_mem_ack   (i_mem_ack),
      .i_mem_rdata (i_mem_rdata)
   );

endmodule

//--- testbench/serial_seq_model.svh
`ifndef SERIAL_SEQ_MODEL_SVH
`define SERIAL_SEQ_MODEL_SVH

localparam int PROG_LEN = 60;

typedef struct packed {
   logic        we;
   logic [31:0] adr;
   logic [31:0] dat;
} bus_txn_t;

bus_txn_t    expected[$];         // bus transfers in the order the model predicts
logic [31:0] mem [logic [31:0]];  // sparse memory holding program and results
int          checks_done;
int          value_errors;
int          transfers_seen;

task automatic check_equal(string name, logic [31:0] exp, logic [31:0] act);
   checks_done++;
   if (exp !== act) begin
      value_errors++;
      $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
   end
endtask

function automatic bus_txn_t make_txn(logic we, logic [31:0] adr, logic [31:0] dat);
   bus_txn_t t;
   t.we  = we;
   t.adr = adr;
   t.dat = dat;
   return t;
endfunction

function automatic logic [31:0] slot_adr(int slot);
   return RESET_PC + 32'(4 * slot);
endfunction

// filler outside the program runs as a plain pc+4
function automatic logic [31:0] read_word(logic [31:0] adr);
   if (mem.exists(adr)) begin
      return mem[adr];
   end
   return {adr[31:7] ^ 25'(adr[6:0]), 7'b0010011};
endfunction

// every slot runs exactly once, so no jump can close a loop
task automatic build_program();
   bit          visited [PROG_LEN+1];
   int          cur;
   int          nxt;
   int          left;
   int unsigned pick;
   int unsigned kind;
   bit          seq_ok;
   logic [4:0]  rd;
   logic [31:0] pc;
   logic [31:0] off;
   logic [31:0] imm;
   logic [31:0] word;
   logic [31:0] rd_val;
   cur  = 0;
   left = PROG_LEN;
   expected.push_back(make_txn(1'b0, slot_adr(0), '0));
   while (cur != PROG_LEN) begin
      visited[cur] = 1'b1;
      left--;
      pc     = slot_adr(cur);
      rd     = 5'($urandom_range(0, 31));
      kind   = $urandom_range(0, 3);
      seq_ok = (cur + 1 < PROG_LEN) ? !visited[cur+1] : (left == 0);
      nxt    = cur + 1;
      if (!seq_ok || kind == 0) begin
         nxt = PROG_LEN;
         if (left != 0) begin
            pick = $urandom_range(0, left - 1);
            nxt  = 0;
            while (visited[nxt] || pick != 0) begin
               if (!visited[nxt]) pick--;
               nxt++;
            end
         end
         off      = slot_adr(nxt) - pc;  // negative when jumping back into a hole
         word     = {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
         word[21] = 1'($urandom_range(0, 1));  // ignored because targets are word aligned
         rd_val   = pc + 32'd4;
      end else if (kind != 3) begin
         imm    = $urandom() & 32'hffff_f000;
         word   = {imm[31:12], rd, (kind == 1) ? OP_AUIPC : OP_LUI};
         rd_val = (kind == 1) ? pc + imm : imm;
      end else begin
         word = $urandom();
         if (word[6:0] == OP_JAL || word[6:0] == OP_AUIPC || word[6:0] == OP_LUI) begin
            word[6:0] = 7'b0010011;
         end
      end
      mem[pc] = word;
      if (word[6:0] != 7'b0010011 && !(kind == 3 && seq_ok) && rd != 5'd0) begin
         expected.push_back(make_txn(1'b1, RESULT_BASE + 32'(rd) * 4, rd_val));
      end
      expected.push_back(make_txn(1'b0, slot_adr(nxt), '0));
      cur = nxt;
   end
endtask

// compares one finished bus transfer with the next predicted one
task automatic check_transfer(logic we, logic [31:0] adr, logic [31:0] wdata);
   bus_txn_t exp;
   string    kind;
   if (expected.size() == 0) begin
      return;
   end
   exp  = expected.pop_front();
   kind = exp.we ? "write-back" : "fetch";
   if (transfers_seen == 0) begin
      check_equal("reset fetch address", RESET_PC, adr);
   end
   check_equal($sformatf("bus order %0d (%s)", transfers_seen, kind), 32'(exp.we), 32'(we));
   check_equal($sformatf("%s %0d address", kind, transfers_seen), exp.adr, adr);
   if (exp.we) begin
      check_equal($sformatf("write-back %0d data", transfers_seen), exp.dat, wdata);
   end
   transfers_seen++;
endtask

`endif

//--- testbench/serial_seq_tb.sv
`timescale 1ns/1ns

module serial_seq_tb;
   import seq_isa_pkg::*;
   import seq_bus_pkg::*;

   `include "serial_seq_model.svh"

   localparam int CLK_PERIOD   = 8;
   localparam int RESET_CYCLES = 16;
   localparam int MAX_DELAY    = 5;
   // counter run plus two transfers at worst delay plus handshake overhead
   localparam int INSTR_CYCLES = 32 + 2 * (MAX_DELAY + 1) + 8;
   localparam int WATCHDOG_NS  = (RESET_CYCLES + (PROG_LEN + 2) * INSTR_CYCLES) * CLK_PERIOD;

   logic        clk;
   logic        i_rst;
   logic        o_mem_req;
   logic        o_mem_we;
   logic [31:0] o_mem_adr;
   logic [31:0] o_mem_wdata;
   logic        i_mem_ack;
   logic [31:0] i_mem_rdata;
   int          proto_errors;

   serial_seq_top serial_seq_top_i (
      .clk         (clk),
      .i_rst       (i_rst),
      .o_mem_req   (o_mem_req),
      .o_mem_we    (o_mem_we),
      .o_mem_adr   (o_mem_adr),
      .o_mem_wdata (o_mem_wdata),
      .i_mem_ack   (i_mem_ack),
      .i_mem_rdata (i_mem_rdata)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   task automatic flag_protocol(string what);
      proto_errors++;
      $display("protocol error at %0t ns: %s", $time, what);
   endtask

   // four-phase responder that samples and drives 1 ns after the rising edge
   task automatic serve_memory();
      int unsigned delay;
      logic        we;
      logic [31:0] adr;
      logic [31:0] wdata;
      forever begin
         @(posedge clk);
         #1;
         if (!i_rst && o_mem_req) begin
            delay = $urandom_range(0, MAX_DELAY);
            repeat (delay) begin
               @(posedge clk);
               #1;
               if (!o_mem_req) flag_protocol("o_mem_req fell before the memory acknowledged it");
            end
            we    = o_mem_we;
            adr   = o_mem_adr;
            wdata = o_mem_wdata;
            if (we) begin
               mem[adr] = wdata;
            end else begin
               i_mem_rdata = read_word(adr);
            end
            i_mem_ack = 1'b1;
            check_transfer(we, adr, wdata);
            do begin
               @(posedge clk);
               #1;
            end while (o_mem_req);
            delay = $urandom_range(0, 1);  // ack sometimes lingers after req drops
            repeat (delay) begin
               @(posedge clk);
               #1;
               if (o_mem_req) flag_protocol("o_mem_req rose while i_mem_ack was still high");
            end
            i_mem_ack = 1'b0;
         end
      end
   endtask

   initial begin
      i_rst       = 1'b1;
      i_mem_ack   = 1'b0;
      i_mem_rdata = '0;
      void'($urandom(34));
      build_program();
      fork
         serve_memory();
         begin
            #(WATCHDOG_NS);
            $display("watchdog expired with %0d bus transfers still missing", expected.size());
            $display("tests failed");
            $finish;
         end
      join_none
      repeat (RESET_CYCLES) @(posedge clk);
      #1 i_rst = 1'b0;
      while (expected.size() != 0) @(posedge clk);
      $display("checks %0d, value errors %0d, protocol errors %0d",
               checks_done, value_errors, proto_errors);
      if (value_errors == 0 && proto_errors == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

//--- serial_seq_top.f
+incdir+testbench
verilog/seq_isa_pkg.sv
verilog/seq_bus_pkg.sv
verilog/mem_req_if.sv
verilog/serial_shift_reg.sv
verilog/serial_counter.sv
verilog/serial_pc_ctrl.sv
verilog/instr_decoder.sv
verilog/rd_writeback.sv
verilog/mem_arbiter.sv
verilog/serial_seq_top.sv
testbench/serial_seq_tb.sv

//--- Bender.yml
package:
  name: serial_seq

sources:
  - verilog/seq_isa_pkg.sv
  - verilog/seq_bus_pkg.sv
  - verilog/mem_req_if.sv
  - verilog/serial_shift_reg.sv
  - verilog/serial_counter.sv
  - verilog/serial_pc_ctrl.sv
  - verilog/instr_decoder.sv
  - verilog/rd_writeback.sv
  - verilog/mem_arbiter.sv
  - verilog/serial_seq_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/serial_seq_tb.sv
